// ==== common/memsys_pkg.sv ====
`default_nettype none

package memsys_pkg;

  localparam int unsigned data_width = 32;
  localparam int unsigned addr_width = 16;

  localparam int unsigned num_banks = 4;
  localparam int unsigned bank_bits = 2;
  localparam int unsigned byte_bits = 2;
  localparam int unsigned word_bits = 10;
  localparam int unsigned bank_depth = 1024;

  // address bits above the word index, ignored by the decode.
  localparam int unsigned pad_bits = addr_width - word_bits - bank_bits - byte_bits;

  localparam int unsigned burst_bits = 2;

  // cycles added to burst_len so waitrequest covers router, bank and merge.
  localparam int unsigned busy_extra = 4;
  localparam int unsigned busy_bits = $clog2((2 ** burst_bits) + busy_extra);

  // beats per burst are value + 1; the value also serves as wrap mask.
  typedef logic [burst_bits-1:0] burst_len_t;

  typedef struct packed {
    logic [pad_bits-1:0]  pad;       // unused upper bits.
    logic [word_bits-1:0] word;      // word index inside a bank.
    logic [bank_bits-1:0] bank;      // bank select.
    logic [byte_bits-1:0] byte_off;  // byte offset, ignored.
  } mem_addr_fields_t;

  typedef union packed {
    logic [addr_width-1:0] raw;     // flat byte address as driven on the port.
    mem_addr_fields_t      fields;
  } mem_addr_u;

endpackage

`default_nettype wire

// ==== verilog/bank_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_router import memsys_pkg::*; (
  input  wire                        clock,
  input  wire                        reset_n,

  input  wire mem_addr_u             addr,
  input  wire burst_len_t            burst_len,
  input  wire logic [data_width-1:0] data_in,
  input  wire                        wr,
  input  wire                        rd,
  output logic                       waitrequest,

  output logic [num_banks-1:0]       bank_wr,
  output logic [num_banks-1:0]       bank_rd,
  output logic [word_bits-1:0]       word_index,
  output logic [data_width-1:0]      bank_data,
  output burst_len_t                 bank_burst_len
);

  logic                  accept;
  logic                  req_wr;
  logic                  req_rd;
  mem_addr_u             req_addr;
  logic [data_width-1:0] req_data;
  burst_len_t            req_burst_len;
  logic [num_banks-1:0]  bank_onehot;
  logic [busy_bits-1:0]  busy_count;

  assign accept = (wr | rd) & ~waitrequest;
  assign waitrequest = (busy_count != '0);

  assign bank_onehot = num_banks'(1) << req_addr.fields.bank;

  // request stage, write wins over read.
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      req_wr <= 1'b0;
      req_rd <= 1'b0;
    end else begin
      req_wr <= accept & wr;
      req_rd <= accept & rd & ~wr;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_addr      <= addr;
      req_data      <= data_in;
      req_burst_len <= burst_len;
    end
  end

  // steer stage.
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      bank_wr <= '0;
      bank_rd <= '0;
    end else begin
      bank_wr <= req_wr ? bank_onehot : '0;
      bank_rd <= req_rd ? bank_onehot : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (req_wr || req_rd) begin
      word_index     <= req_addr.fields.word;
      bank_data      <= req_data;
      bank_burst_len <= req_burst_len;
    end
  end

  // holds off new requests until the burst has left the merge.
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      busy_count <= '0;
    end else if (accept && rd && !wr) begin
      busy_count <= busy_bits'(burst_len) + busy_bits'(busy_extra);
    end else if (busy_count != '0) begin
      busy_count <= busy_count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== burst_bank/burst_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_bank import memsys_pkg::*; (
  input  wire                        clock,
  input  wire                        reset_n,

  input  wire logic [word_bits-1:0]  word_index,
  input  wire burst_len_t            burst_len,
  input  wire logic [data_width-1:0] data_in,
  input  wire                        wr,
  input  wire                        rd,

  output logic [data_width-1:0]      data_out,
  output logic                       rd_valid
);

  typedef enum logic {
    st_idle,
    st_burst
  } state_t;

  logic [data_width-1:0] mem [bank_depth];

  state_t                state;
  state_t                next_state;

  burst_len_t            beat_count;
  burst_len_t            burst_mask;
  logic [word_bits-1:0]  burst_index;
  logic [word_bits-1:0]  wrap_mask;

  logic                  load_burst;
  logic                  step_burst;

  assign wrap_mask = word_bits'(burst_mask);

  always_ff @(posedge clock) begin
    if (wr) begin
      mem[word_index] <= data_in;
    end
  end

  // beat counter and wrapping word index.
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      beat_count  <= '0;
      burst_mask  <= '0;
      burst_index <= '0;
    end else if (load_burst) begin
      beat_count  <= burst_len;
      burst_mask  <= burst_len;
      burst_index <= word_index;
    end else if (step_burst && beat_count != '0) begin
      beat_count <= beat_count - 1'b1;
      // wrap inside the aligned block of burst_len+1 words.
      if ((burst_index & wrap_mask) == wrap_mask) begin
        burst_index <= burst_index & ~wrap_mask;
      end else begin
        burst_index <= burst_index + 1'b1;
      end
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= step_burst;
    end
  end

  always_ff @(posedge clock) begin
    if (step_burst) begin
      data_out <= mem[burst_index];
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    load_burst = 1'b0;
    step_burst = 1'b0;

    case (state)
      st_idle: begin
        load_burst = 1'b1;  // track the inputs until a read arrives.
        if (rd) begin
          next_state = st_burst;
        end
      end

      st_burst: begin
        step_burst = 1'b1;
        if (beat_count == '0) begin
          next_state = st_idle;  // last beat issued.
        end
      end

      default: begin
        next_state = st_idle;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/read_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_merge import memsys_pkg::*; (
  input  wire                        clock,
  input  wire                        reset_n,

  input  wire logic [num_banks-1:0]  bank_valid,
  input  wire logic [data_width-1:0] bank_data [num_banks],

  output logic                       rd_valid,
  output logic [data_width-1:0]      data_out
);

  logic [data_width-1:0] sel_data;
  logic                  any_valid;

  assign any_valid = |bank_valid;

  // and-or select, only one bank bursts at a time.
  always_comb begin
    sel_data = '0;
    for (int i = 0; i < num_banks; i++) begin
      if (bank_valid[i]) begin
        sel_data = sel_data | bank_data[i];
      end
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= any_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (any_valid) begin
      data_out <= sel_data;  // holds between beats.
    end
  end

endmodule

`default_nettype wire

// ==== verilog/memsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_top import memsys_pkg::*; (
  input  wire                        clock,
  input  wire                        reset_n,

  input  wire mem_addr_u             addr,
  input  wire burst_len_t            burst_len,
  input  wire logic [data_width-1:0] data_in,
  input  wire                        wr,
  input  wire                        rd,
  output logic                       waitrequest,

  output logic                       rd_valid,
  output logic [data_width-1:0]      data_out
);

  logic [num_banks-1:0]  bank_wr;
  logic [num_banks-1:0]  bank_rd;
  logic [word_bits-1:0]  word_index;
  logic [data_width-1:0] bank_data;
  burst_len_t            bank_burst_len;

  logic [num_banks-1:0]  bank_valid;
  logic [data_width-1:0] bank_rdata [num_banks];

  bank_router i_router (
    .clock          (clock),
    .reset_n        (reset_n),
    .addr           (addr),
    .burst_len      (burst_len),
    .data_in        (data_in),
    .wr             (wr),
    .rd             (rd),
    .waitrequest    (waitrequest),
    .bank_wr        (bank_wr),
    .bank_rd        (bank_rd),
    .word_index     (word_index),
    .bank_data      (bank_data),
    .bank_burst_len (bank_burst_len)
  );

  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    burst_bank i_bank (
      .clock      (clock),
      .reset_n    (reset_n),
      .word_index (word_index),
      .burst_len  (bank_burst_len),
      .data_in    (bank_data),
      .wr         (bank_wr[i]),
      .rd         (bank_rd[i]),
      .data_out   (bank_rdata[i]),
      .rd_valid   (bank_valid[i])
    );
  end

  read_merge i_merge (
    .clock      (clock),
    .reset_n    (reset_n),
    .bank_valid (bank_valid),
    .bank_data  (bank_rdata),
    .rd_valid   (rd_valid),
    .data_out   (data_out)
  );

endmodule

`default_nettype wire

// ==== verif/memsys_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_properties import memsys_pkg::*; (
  input wire                       clock,
  input wire                       reset_n,
  input wire logic [num_banks-1:0] strobes,
  input wire                       quiet_in_reset,
  input wire                       out_valid,
  input wire                       src_valid
);

  int fail_count = 0;

  a_strobes_onehot: assert property (@(posedge clock) disable iff (!reset_n)
    $onehot0(strobes))
    else begin
      $error("bank strobes not zero-or-one-hot: %b", strobes);
      fail_count++;
    end

  a_low_in_reset: assert property (@(posedge clock) !reset_n |-> !quiet_in_reset)
    else begin
      $error("output high while reset_n is low");
      fail_count++;
    end

  // a valid only follows a cycle in which a read was still pending.
  a_valid_has_source: assert property (@(posedge clock) disable iff (!reset_n)
    out_valid |-> $past(src_valid))
    else begin
      $error("valid raised with no read pending");
      fail_count++;
    end

endmodule

bind bank_router memsys_properties i_props (
  .clock          (clock),
  .reset_n        (reset_n),
  .strobes        (bank_wr | bank_rd),
  .quiet_in_reset (waitrequest),
  .out_valid      (|bank_rd),
  .src_valid      (waitrequest)
);

bind read_merge memsys_properties i_props (
  .clock          (clock),
  .reset_n        (reset_n),
  .strobes        (bank_valid),
  .quiet_in_reset (rd_valid),
  .out_valid      (1'b0),
  .src_valid      (1'b0)
);

`default_nettype wire

// ==== verif/memsys_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_checker import memsys_pkg::*; (
  input  wire                        clock,
  input  wire                        reset_n,
  input  wire mem_addr_u             addr,
  input  wire burst_len_t            burst_len,
  input  wire logic [data_width-1:0] data_in,
  input  wire                        wr,
  input  wire                        rd,
  input  wire                        waitrequest,
  input  wire                        rd_valid,
  input  wire logic [data_width-1:0] data_out,
  output int                         error_count,
  output int                         beat_count,
  output int                         pending_beats
);

  logic [data_width-1:0] model [num_banks][bank_depth];
  logic [data_width-1:0] expect_q [$];
  int                    cycle;
  int                    busy_until;
  int                    first_due;  // 0 while no first beat is awaited.

  // next word of a burst, wrapping inside the aligned block of burst_len+1 words.
  function automatic logic [word_bits-1:0] wrap_next(input logic [word_bits-1:0] idx,
                                                     input burst_len_t bl);
    logic [word_bits-1:0] mask;
    logic [word_bits-1:0] result;
    mask = word_bits'(bl);
    if ((idx & mask) == mask) begin
      result = idx & ~mask;
    end else begin
      result = idx + word_bits'(1);
    end
    return result;
  endfunction

  always @(posedge clock) begin : sample
    logic [word_bits-1:0]  idx;
    logic [data_width-1:0] expected;
    logic                  wait_expected;

    if (!reset_n) begin
      expect_q.delete();
      error_count   = 0;
      beat_count    = 0;
      pending_beats = 0;
      cycle         = 0;
      busy_until    = 0;
      first_due     = 0;
    end else begin
      cycle++;
      wait_expected = (cycle <= busy_until);
      if (waitrequest !== wait_expected) begin
        $display("FAIL waitrequest expected %h got %h", wait_expected, waitrequest);
        error_count++;
      end
      if (first_due != 0 && (rd_valid || cycle > first_due)) begin
        if (cycle != first_due) begin
          $display("first read beat came at cycle %0d, it was due at cycle %0d",
                   cycle, first_due);
          error_count++;
        end
        first_due = 0;
      end
      if (rd_valid) begin
        beat_count++;
        if (expect_q.size() == 0) begin
          $display("read beat arrived with no read burst pending, data %h", data_out);
          error_count++;
        end else begin
          expected = expect_q.pop_front();
          if (data_out !== expected) begin
            $display("FAIL data_out expected %h got %h", expected, data_out);
            error_count++;
          end
        end
      end
      if ((wr || rd) && !waitrequest) begin
        if (wr) begin
          model[addr.fields.bank][addr.fields.word] = data_in;
        end else begin
          if (expect_q.size() != 0) begin
            $display("read accepted while %0d beats of the last burst were still due",
                     expect_q.size());
            error_count++;
          end
          idx = addr.fields.word;
          for (int n = 0; n <= int'(burst_len); n++) begin
            expect_q.push_back(model[addr.fields.bank][idx]);
            idx = wrap_next(idx, burst_len);
          end
          busy_until = cycle + int'(burst_len) + int'(busy_extra);
          first_due  = cycle + 5;  // router, steer, bank load, bank read, merge.
        end
      end
      pending_beats = expect_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== verif/memsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_tb import memsys_pkg::*; ();

  localparam int window_words = 64;
  localparam int max_gap = 3;
  localparam int total_requests = 280;
  // longest burst, busy cycles, accepting edge and longest idle gap per request.
  localparam int timeout_cycles = total_requests * (3 + int'(busy_extra) + 1 + max_gap) + 200;
  localparam logic [word_bits-1:0] window_base = 10'h120;

  logic                  clock = 1'b0;
  logic                  reset_n;
  mem_addr_u             addr;
  burst_len_t            burst_len;
  logic [data_width-1:0] data_in;
  logic                  wr;
  logic                  rd;
  logic                  waitrequest;
  logic                  rd_valid;
  logic [data_width-1:0] data_out;

  int                    error_count;
  int                    beat_count;
  int                    pending_beats;

  logic [31:0]           lcg_state;
  int                    tb_errors;
  int                    issued;
  int                    expected_beats;
  int                    tests_passed;
  int                    tests_failed;

  memsys_top i_dut (
    .clock       (clock),
    .reset_n     (reset_n),
    .addr        (addr),
    .burst_len   (burst_len),
    .data_in     (data_in),
    .wr          (wr),
    .rd          (rd),
    .waitrequest (waitrequest),
    .rd_valid    (rd_valid),
    .data_out    (data_out)
  );

  memsys_checker i_checker (
    .clock         (clock),
    .reset_n       (reset_n),
    .addr          (addr),
    .burst_len     (burst_len),
    .data_in       (data_in),
    .wr            (wr),
    .rd            (rd),
    .waitrequest   (waitrequest),
    .rd_valid      (rd_valid),
    .data_out      (data_out),
    .error_count   (error_count),
    .beat_count    (beat_count),
    .pending_beats (pending_beats)
  );

  always #5 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int limit);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[30:8]) % limit;
  endfunction

  function automatic logic [data_width-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // word n of the window, spread over the banks by its low bits.
  function automatic mem_addr_u window_addr(input int n);
    mem_addr_u a;
    a.fields.pad      = '0;
    a.fields.word     = window_base + word_bits'(n / num_banks);
    a.fields.bank     = bank_bits'(n % num_banks);
    a.fields.byte_off = byte_bits'(rand_below(4));  // decode ignores it.
    return a;
  endfunction

  function automatic int all_errors();
    return tb_errors + error_count + i_dut.i_router.i_props.fail_count
      + i_dut.i_merge.i_props.fail_count;
  endfunction

  task automatic send_request(input mem_addr_u a, input logic is_write,
                              input burst_len_t bl, input logic [data_width-1:0] d);
    addr      = a;
    burst_len = bl;
    data_in   = d;
    wr        = is_write;
    rd        = !is_write;
    while (waitrequest) begin
      @(negedge clock);  // held until the router takes it.
    end
    @(negedge clock);
    wr = 1'b0;
    rd = 1'b0;
    issued++;
    if (!is_write) begin
      expected_beats += int'(bl) + 1;
    end
  endtask

  task automatic write_word(input int n);
    send_request(window_addr(n), 1'b1, '0, rand_word());
  endtask

  task automatic read_burst(input int n, input burst_len_t bl);
    send_request(window_addr(n), 1'b0, bl, '0);
  endtask

  task automatic check_idle();
    if (waitrequest !== 1'b0) begin
      $display("FAIL waitrequest expected %h got %h", 1'b0, waitrequest);
      tb_errors++;
    end
    if (rd_valid !== 1'b0) begin
      $display("FAIL rd_valid expected %h got %h", 1'b0, rd_valid);
      tb_errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    int errors;
    while (waitrequest || pending_beats != 0) begin
      @(negedge clock);
    end
    errors = all_errors() - errors_before;
    if (errors == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors);
    end
  endtask

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clock);
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int start;
    lcg_state = 32'd70606;
    reset_n   = 1'b0;
    addr      = '0;
    burst_len = '0;
    data_in   = '0;
    wr        = 1'b0;
    rd        = 1'b0;
    tb_errors      = 0;
    issued         = 0;
    expected_beats = 0;
    tests_passed   = 0;
    tests_failed   = 0;

    repeat (8) begin
      @(negedge clock);
      check_idle();
    end
    reset_n = 1'b1;
    repeat (2) begin
      @(negedge clock);
      check_idle();
    end
    finish_test("reset state", 0);

    start = all_errors();
    for (int i = 0; i < window_words; i++) begin
      write_word(i);
    end
    for (int i = 0; i < 48; i++) begin
      read_burst(rand_below(window_words), 2'd0);
    end
    finish_test("single-word round trip", start);

    start = all_errors();
    for (int i = 0; i < 32; i++) begin
      read_burst(rand_below(window_words), (rand_below(2) == 0) ? 2'd1 : 2'd3);
    end
    finish_test("wrapping bursts", start);

    start = all_errors();
    for (int i = 0; i < 40; i++) begin
      if (rand_below(3) == 0) begin
        write_word(rand_below(window_words));
      end else begin
        read_burst(rand_below(window_words), burst_len_t'(rand_below(4)));
      end
      repeat (rand_below(max_gap + 1)) @(negedge clock);
    end
    finish_test("back-pressure and beat count", start);

    start = all_errors();
    for (int i = 0; i < 64; i++) begin
      write_word(rand_below(window_words));
    end
    for (int i = 0; i < 32; i++) begin
      read_burst(rand_below(window_words), burst_len_t'(rand_below(4)));
    end
    finish_test("bank interleaving", start);

    if (beat_count != expected_beats) begin
      $display("FAIL beat_count expected %h got %h", expected_beats, beat_count);
      tb_errors++;
    end
    $display("tests passed %0d, failed %0d, requests %0d, beats %0d, errors %0d",
             tests_passed, tests_failed, issued, beat_count, all_errors());
    if (tests_failed == 0 && all_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/memsys_pkg.sv
verilog/bank_router.sv
burst_bank/burst_bank.sv
verilog/read_merge.sv
verilog/memsys_top.sv
verif/memsys_properties.sv
verif/memsys_checker.sv
verif/memsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module memsys_tb -f sim.f \
  --Mdir obj_dir -o memsys_sim

status=0
./obj_dir/memsys_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
grep -q "Simulation passed" sim.log
